// File: common/qbusPkg.sv
// Qbus side definitions for the disk controller front end
// Bus width, PDP-11 device addresses and control register bit map

package qbusPkg;

    ////////////////////////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////////////////////////

    localparam int bdalWidth = 22;               // BDAL address/data lines

    typedef logic [bdalWidth-1:0] qbusWord;

    // Device registers in the I/O page, matched on bits 12 to 1
    localparam qbusWord qaddrIp = 22'o17772150;
    localparam qbusWord qaddrSa = 22'o17772152;

    ////////////////////////////////////////////////////////////
    // Control register bits, host written
    ////////////////////////////////////////////////////////////

    localparam int ctlWidth = 15;

    localparam int ctlSync    = 0;              // Master control lines
    localparam int ctlDin     = 1;
    localparam int ctlDout    = 2;
    localparam int ctlWtbt    = 3;
    localparam int ctlDmr     = 4;              // DMA request
    localparam int ctlRef     = 5;
    localparam int ctlBs7     = 6;
    localparam int ctlIrq4    = 7;
    localparam int ctlIrq5    = 8;
    localparam int ctlIrq6    = 9;
    localparam int ctlAddrEn  = 10;             // Put the DMA address on BDAL
    localparam int ctlDataEn  = 11;             // Put data-out on BDAL
    localparam int ctlClearSa = 12;             // IP read also clears SA address

    // Write-only event bit, never stored
    localparam int ctlDone = 15;

endpackage

// File: common/hostPkg.sv
// Host side definitions for the disk controller front end
// Register offsets on the host bus and the status flag layout

package hostPkg;

    typedef logic [15:0] hostWord;

    localparam int hostAddrWidth = 22;

    // Register offsets seen by the host, word aligned
    localparam logic [hostAddrWidth-1:0] faddrIp      = 22'd0;
    localparam logic [hostAddrWidth-1:0] faddrSa      = 22'd2;
    localparam logic [hostAddrWidth-1:0] faddrCt      = 22'd4;
    localparam logic [hostAddrWidth-1:0] faddrLo      = 22'd6;
    localparam logic [hostAddrWidth-1:0] faddrHi      = 22'd8;
    localparam logic [hostAddrWidth-1:0] faddrDataOut = 22'd10;
    localparam logic [hostAddrWidth-1:0] faddrDataIn  = 22'd12;
    localparam logic [hostAddrWidth-1:0] faddrTest    = 22'd14;

    // Status bits read through IP, ipRead is bit 0
    typedef struct packed {
        logic busAck;           // Live, we own the bus
        logic replyLevel;       // Live, reply asserted on the backplane
        logic replyGone;        // Sticky, reply went high
        logic replySeen;        // Sticky, reply went low
        logic saWritten;
        logic saRead;
        logic ipWritten;
        logic ipRead;
    } statusFlags;

endpackage

// File: host/hostRegs.sv
// Host register file
// Byte enabled writes from the host bus and the combinational read mux
// Also holds the status snapshot returned by IP reads

`timescale 1ns/1ps

module hostRegs import qbusPkg::*, hostPkg::*;
(
    input  logic                     BRPLYf,
    input  logic                     F_IP_read_enable,
    input  logic [hostAddrWidth-1:0] hostAddr,
    input  hostWord                  hostWrData,
    input  logic [1:0]               hostBe,
    input  logic                     hostWr,
    input  logic                     hostRd,
    input  logic                     clearRegs,     // PDP-11 wrote IP
    input  statusFlags               flags,
    input  hostWord                  saAddress,
    input  qbusWord                  bdalIn,
    output hostWord                  hostRdData,
    output logic [ctlWidth-1:0]      ctl,
    output qbusWord                  qAddr,
    output hostWord                  dataOut,
    output hostWord                  saStatus,
    output logic                     testBit,
    output logic                     doneWrite
);

    hostWord    testReg;
    statusFlags flagSnap;                       // Frozen copy for the IP read
    logic       selIp, selSa, selCt, selLo, selHi, selOut, selIn, selTest;

    // Merge new bytes into a word under the byte enables
    function automatic hostWord mergeBytes(hostWord old, hostWord wr, logic [1:0] be);
        hostWord res;
        res = old;
        if (be[0]) res[7:0] = wr[7:0];
        if (be[1]) res[15:8] = wr[15:8];
        return res;
    endfunction

    // Offset decode, bit 0 ignored
    assign selIp   = hostAddr[hostAddrWidth-1:1] == faddrIp[hostAddrWidth-1:1];
    assign selSa   = hostAddr[hostAddrWidth-1:1] == faddrSa[hostAddrWidth-1:1];
    assign selCt   = hostAddr[hostAddrWidth-1:1] == faddrCt[hostAddrWidth-1:1];
    assign selLo   = hostAddr[hostAddrWidth-1:1] == faddrLo[hostAddrWidth-1:1];
    assign selHi   = hostAddr[hostAddrWidth-1:1] == faddrHi[hostAddrWidth-1:1];
    assign selOut  = hostAddr[hostAddrWidth-1:1] == faddrDataOut[hostAddrWidth-1:1];
    assign selIn   = hostAddr[hostAddrWidth-1:1] == faddrDataIn[hostAddrWidth-1:1];
    assign selTest = hostAddr[hostAddrWidth-1:1] == faddrTest[hostAddrWidth-1:1];

    assign doneWrite = hostWr && selCt && hostBe[1] && hostWrData[ctlDone];   // Ends DMA
    assign testBit   = testReg[0];

    ////////////////////////////////////////////////////////////
    // Writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            saStatus <= '0;
            ctl      <= '0;
            qAddr    <= '0;
            dataOut  <= '0;
            testReg  <= '0;
        end
        else if (clearRegs)
        begin
            saStatus <= '0;                     // Test register survives
            ctl      <= '0;
            qAddr    <= '0;
            dataOut  <= '0;
        end
        else if (hostWr)
        begin
            if (selSa) saStatus <= mergeBytes(saStatus, hostWrData, hostBe);
            if (selCt) ctl <= ctlWidth'(mergeBytes({1'b0, ctl}, hostWrData, hostBe));
            if (selLo) qAddr[15:0] <= mergeBytes(qAddr[15:0], hostWrData, hostBe);
            if (selHi && hostBe[0]) qAddr[21:16] <= hostWrData[5:0];  // Only six bits
            if (selOut) dataOut <= mergeBytes(dataOut, hostWrData, hostBe);
            if (selTest) testReg <= mergeBytes(testReg, hostWrData, hostBe);
        end
    end

    // Track the flags until a read starts, then hold
    always_ff @(posedge BRPLYf)
    begin
        if (!hostRd)
            flagSnap <= flags;
    end

    ////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        hostRdData = '0;
        if (hostRd)
        begin
            if (selIp)        hostRdData = {8'b0, flagSnap};
            else if (selSa)   hostRdData = saAddress;
            else if (selCt)   hostRdData = {1'b0, ctl};
            else if (selLo)   hostRdData = qAddr[15:0];
            else if (selHi)   hostRdData = {10'b0, qAddr[21:16]};
            else if (selOut)  hostRdData = dataOut;
            else if (selIn)   hostRdData = ~bdalIn[15:0];   // Live bus, true sense
            else if (selTest) hostRdData = testReg;
        end
    end

endmodule

// File: qbus/qbusSlave.sv
// Qbus slave for the IP and SA registers
// Address capture, event flags for the host, SA address register,
// reply generation and the slave read request

`timescale 1ns/1ps

module qbusSlave import qbusPkg::*, hostPkg::*;
(
    input  logic       BRPLYf,
    input  logic       F_IP_read_enable,
    input  qbusWord    bdalIn,
    input  logic       qSyncIn,
    input  logic       qDinIn,
    input  logic       qDoutIn,
    input  logic       qWtbtIn,
    input  logic       qBs7In,
    input  logic       qInitIn,
    input  logic       qReplyIn,
    input  logic       busAck,
    input  logic       hostIpRead,      // Host is reading IP, level
    input  logic       clearSa,
    input  logic       testBit,
    input  hostWord    saStatus,
    output statusFlags flags,
    output hostWord    saAddress,
    output logic       slaveReq,
    output qbusWord    slaveData,
    output logic       replyOut,
    output logic       hostIrq,
    output logic       clearRegs
);

    qbusWord busVal;
    logic    syncPrev, dinPrev, doutPrev, replyPrev, ipReadPrev;
    logic    ipSel, saSel, addrOdd;
    logic    ipRead, ipWritten, saRead, saWritten, replySeen, replyGone;
    logic    driveGate;
    logic    addrStart, writeEvt, readEvt, replyRise, flagClear;

    assign busVal    = ~bdalIn;                         // Bus is active low
    assign addrStart = !qSyncIn && syncPrev;
    assign writeEvt  = !qDoutIn && doutPrev;
    assign readEvt   = !qDinIn && dinPrev;
    assign replyRise = qReplyIn && !replyPrev;
    assign flagClear = ipReadPrev && !hostIpRead;       // End of host IP read
    assign clearRegs = writeEvt && ipSel;

    // Previous samples for edge detection, lines idle high
    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            syncPrev   <= 1'b1;
            dinPrev    <= 1'b1;
            doutPrev   <= 1'b1;
            replyPrev  <= 1'b1;
            ipReadPrev <= 1'b0;
        end
        else
        begin
            syncPrev   <= qSyncIn;
            dinPrev    <= qDinIn;
            doutPrev   <= qDoutIn;
            replyPrev  <= qReplyIn;
            ipReadPrev <= hostIpRead;
        end
    end

    // Address phase, I/O page only
    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            ipSel   <= 1'b0;
            saSel   <= 1'b0;
            addrOdd <= 1'b0;
        end
        else if (!qInitIn)
        begin
            ipSel <= 1'b0;                      // Bus init drops any select
            saSel <= 1'b0;
        end
        else if (addrStart)
        begin
            ipSel   <= !qBs7In && busVal[12:1] == qaddrIp[12:1];
            saSel   <= !qBs7In && busVal[12:1] == qaddrSa[12:1];
            addrOdd <= busVal[0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Event flags and SA address
    ////////////////////////////////////////////////////////////

    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            {ipRead, ipWritten, saRead, saWritten} <= '0;
            {replySeen, replyGone}                 <= '0;
            saAddress                              <= '0;
        end
        else
        begin
            if (flagClear)
            begin
                {ipRead, ipWritten, saRead, saWritten} <= '0;
                {replySeen, replyGone}                 <= '0;
                if (clearSa) saAddress <= '0;
            end
            // New events win over the clear
            if (readEvt && ipSel) ipRead <= 1'b1;
            if (readEvt && saSel) saRead <= 1'b1;
            if (writeEvt && ipSel) ipWritten <= 1'b1;
            if (writeEvt && saSel)
            begin
                saWritten <= 1'b1;
                if (qWtbtIn || !addrOdd) saAddress[7:0] <= busVal[7:0];     // Low byte
                if (qWtbtIn || addrOdd) saAddress[15:8] <= busVal[15:8];    // High byte
            end
            if (!qReplyIn && replyPrev) replySeen <= 1'b1;
            if (replyRise) replyGone <= 1'b1;
        end
    end

    // Reply trails the sampled strobe by one clock, drive lasts until reply ends
    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            replyOut  <= 1'b0;
            driveGate <= 1'b0;
        end
        else
        begin
            replyOut <= (ipSel || saSel) && !busAck && (!dinPrev || !doutPrev);
            if (readEvt)        driveGate <= 1'b1;
            else if (replyRise) driveGate <= 1'b0;
        end
    end

    assign slaveReq  = driveGate && (ipSel || saSel);
    assign slaveData = saSel ? qbusWord'(saStatus) : '0;    // IP reads as zero

    assign flags = '{busAck: busAck, replyLevel: !qReplyIn, replyGone: replyGone,
                     replySeen: replySeen, saWritten: saWritten, saRead: saRead,
                     ipWritten: ipWritten, ipRead: ipRead};

    assign hostIrq = ipRead || ipWritten || saRead || saWritten || testBit;

endmodule

// File: qbus/busMaster.sv
// Qbus master side, timed by the host through the control register
// Drives the control lines, takes the DMA grant and presents address or data

`timescale 1ns/1ps

module busMaster import qbusPkg::*;
(
    input  logic                BRPLYf,
    input  logic                F_IP_read_enable,
    input  logic [ctlWidth-1:0] ctl,
    input  logic                qDmgIn,
    input  logic                qSyncIn,
    input  logic                qReplyIn,
    input  logic                doneWrite,
    input  qbusWord             qAddr,
    input  logic [15:0]         dataOut,
    output logic                qSyncOut,
    output logic                qDinOut,
    output logic                qDoutOut,
    output logic                qWtbtOut,
    output logic                qDmrOut,
    output logic                qRefOut,
    output logic                qBs7Out,
    output logic                qIrq4Out,
    output logic                qIrq5Out,
    output logic                qIrq6Out,
    output logic                dmgOut,
    output logic                busAck,
    output logic                masterReq,
    output qbusWord             masterData
);

    // Host owns the control lines outright
    assign qSyncOut = ctl[ctlSync];
    assign qDinOut  = ctl[ctlDin];
    assign qDoutOut = ctl[ctlDout];
    assign qWtbtOut = ctl[ctlWtbt];
    assign qDmrOut  = ctl[ctlDmr];
    assign qRefOut  = ctl[ctlRef];
    assign qBs7Out  = ctl[ctlBs7];
    assign qIrq4Out = ctl[ctlIrq4];
    assign qIrq5Out = ctl[ctlIrq5];
    assign qIrq6Out = ctl[ctlIrq6];

    // Take the grant only with the bus idle, hold until the host is done
    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
            busAck <= 1'b0;
        else if (doneWrite)
            busAck <= 1'b0;
        else if (!qDmgIn && ctl[ctlDmr] && qSyncIn && qReplyIn)
            busAck <= 1'b1;
    end

    assign dmgOut = !qDmgIn && !ctl[ctlDmr] && !busAck;    // Pass grant down the chain

    assign masterReq  = busAck && (ctl[ctlAddrEn] || ctl[ctlDataEn]);
    assign masterData = ctl[ctlAddrEn] ? qAddr : qbusWord'(dataOut);  // Address first

endmodule

// File: logic/bdalArbiter.sv
// BDAL driver arbiter
// Master and slave share the bus drivers, the master always wins

`timescale 1ns/1ps

module bdalArbiter import qbusPkg::*;
#(
    parameter type payloadT = qbusWord
)
(
    input  logic    masterReq,
    input  payloadT masterData,
    input  logic    slaveReq,
    input  payloadT slaveData,
    output payloadT bdalOut,
    output payloadT bdalOe,
    output logic    outbound
);

    ////////////////////////////////////////////////////////////
    // Fixed priority select
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        bdalOut  = '0;                  // Drivers off by default
        bdalOe   = '0;
        outbound = 1'b0;
        if (masterReq)
        begin
            bdalOut  = masterData;
            bdalOe   = '1;
            outbound = 1'b1;            // Open the gate drivers
        end
        else if (slaveReq)
        begin
            bdalOut  = slaveData;
            bdalOe   = '1;
            outbound = 1'b1;
        end
    end

endmodule

// File: logic/qbusBridge.sv
// Qbus disk controller front end, top level
// Connects the host register file, the Qbus slave and master and the BDAL arbiter

`timescale 1ns/1ps

module qbusBridge import qbusPkg::*, hostPkg::*;
(
    input  logic                     BRPLYf,
    input  logic                     F_IP_read_enable,
    input  logic [hostAddrWidth-1:0] hostAddr,
    input  hostWord                  hostWrData,
    input  logic [1:0]               hostBe,
    input  logic                     hostWr,
    input  logic                     hostRd,
    output hostWord                  hostRdData,
    output logic                     hostIrq,
    input  qbusWord                  bdalIn,
    input  logic                     qSyncIn,
    input  logic                     qDinIn,
    input  logic                     qDoutIn,
    input  logic                     qWtbtIn,
    input  logic                     qBs7In,
    input  logic                     qDmgIn,
    input  logic                     qInitIn,
    input  logic                     qReplyIn,
    output qbusWord                  bdalOut,
    output qbusWord                  bdalOe,
    output logic                     outbound,
    output logic                     replyOut,
    output logic                     qSyncOut,
    output logic                     qDinOut,
    output logic                     qDoutOut,
    output logic                     qWtbtOut,
    output logic                     qDmrOut,
    output logic                     qRefOut,
    output logic                     qBs7Out,
    output logic                     qIrq4Out,
    output logic                     qIrq5Out,
    output logic                     qIrq6Out,
    output logic                     dmgOut,
    output logic                     busAck
);

    logic [ctlWidth-1:0] ctl;
    qbusWord             qAddr, slaveData, masterData;
    hostWord             dataOut, saStatus, saAddress;
    statusFlags          flags;
    logic                testBit, doneWrite, clearRegs, slaveReq, masterReq;
    logic                hostIpRead, clearSa;

    assign hostIpRead = hostRd && hostAddr[hostAddrWidth-1:1] == faddrIp[hostAddrWidth-1:1];
    assign clearSa    = ctl[ctlClearSa];

    hostRegs regs0 (
        .BRPLYf, .F_IP_read_enable, .hostAddr, .hostWrData, .hostBe, .hostWr, .hostRd,
        .clearRegs, .flags, .saAddress, .bdalIn, .hostRdData, .ctl, .qAddr, .dataOut,
        .saStatus, .testBit, .doneWrite
    );

    qbusSlave slave0 (
        .BRPLYf, .F_IP_read_enable, .bdalIn, .qSyncIn, .qDinIn, .qDoutIn, .qWtbtIn,
        .qBs7In, .qInitIn, .qReplyIn, .busAck, .hostIpRead, .clearSa, .testBit, .saStatus,
        .flags, .saAddress, .slaveReq, .slaveData, .replyOut, .hostIrq, .clearRegs
    );

    busMaster master0 (
        .BRPLYf, .F_IP_read_enable, .ctl, .qDmgIn, .qSyncIn, .qReplyIn, .doneWrite, .qAddr,
        .dataOut, .qSyncOut, .qDinOut, .qDoutOut, .qWtbtOut, .qDmrOut, .qRefOut, .qBs7Out,
        .qIrq4Out, .qIrq5Out, .qIrq6Out, .dmgOut, .busAck, .masterReq, .masterData
    );

    bdalArbiter #(.payloadT(qbusWord)) arb0 (
        .masterReq, .masterData, .slaveReq, .slaveData, .bdalOut, .bdalOe, .outbound
    );

endmodule

// File: testbench/tbBridge.sv
// Testbench for the Qbus disk controller front end
// Replays the stimulus and expect trace against the DUT, one step per clock
// Inputs change on the falling edge and outputs are checked late in the cycle

`timescale 1ns/1ps

module tbBridge import qbusPkg::*, hostPkg::*;
();

    localparam int maxSteps = 128;

    logic                     BRPLYf, F_IP_read_enable;
    logic [hostAddrWidth-1:0] hostAddr;
    hostWord                  hostWrData, hostRdData;
    logic [1:0]               hostBe;
    logic                     hostWr, hostRd, hostIrq;
    qbusWord                  bdalIn, bdalOut, bdalOe;
    logic                     qSyncIn, qDinIn, qDoutIn, qWtbtIn, qBs7In, qDmgIn, qInitIn;
    logic                     qReplyIn;
    logic                     outbound, replyOut, dmgOut, busAck;
    logic                     qSyncOut, qDinOut, qDoutOut, qWtbtOut, qDmrOut;
    logic                     qRefOut, qBs7Out, qIrq4Out, qIrq5Out, qIrq6Out;
    logic [15:0]              sigVec;          // Single-bit outputs in trace column order

    // Trace columns with one entry per step
    logic [hostAddrWidth-1:0] stAddr    [maxSteps];
    hostWord                  stWrData  [maxSteps];
    logic [3:0]               stHostCtl [maxSteps];   // be[1:0], rd, wr
    qbusWord                  stBdal    [maxSteps];
    logic [7:0]               stQin     [maxSteps];   // reply init dmg bs7 wtbt dout din sync
    hostWord                  stExpRd   [maxSteps];
    qbusWord                  stExpOut  [maxSteps];
    logic [15:0]              stExpSig  [maxSteps];
    logic [3:0]               stMask    [maxSteps];   // Bit 0 read data, 1 bdalOut, 2 lines
    int                       nSteps;
    logic                     traceLoaded;

    assign sigVec = {qIrq6Out, qIrq5Out, qIrq4Out, qBs7Out, qRefOut, qDmrOut, qWtbtOut,
                     qDoutOut, qDinOut, qSyncOut, &bdalOe, busAck, dmgOut, replyOut,
                     outbound, hostIrq};

    qbusBridge dut0 (.*);

    initial
    begin
        BRPLYf = 1'b0;
        forever #50 BRPLYf = ~BRPLYf;               // 100 ns period
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input logic [31:0] got, input logic [31:0] want,
                              input string what);
        if (got !== want)
        begin
            $display("ERR %0d ns: %s is %h, expected %h", $time, what, got, want);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic loadTrace();
        int                       fd;
        int                       cnt;
        string                    line;
        logic [hostAddrWidth-1:0] a;
        hostWord                  d, er;
        logic [3:0]               hc, m;
        qbusWord                  b, eo;
        logic [7:0]               q;
        logic [15:0]              es;
        fd = $fopen("testbench/bridgeTrace.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the trace file testbench/bridgeTrace.txt");
            $display("RESULT: FAIL");
            $fatal(1, "Trace file missing");
        end
        nSteps = 0;
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != 8'h23 && nSteps < maxSteps)   // Skip # lines
            begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h", a, d, hc, b, q, er, eo, es, m);
                if (cnt == 9)
                begin
                    stAddr[nSteps]    = a;
                    stWrData[nSteps]  = d;
                    stHostCtl[nSteps] = hc;
                    stBdal[nSteps]    = b;
                    stQin[nSteps]     = q;
                    stExpRd[nSteps]   = er;
                    stExpOut[nSteps]  = eo;
                    stExpSig[nSteps]  = es;
                    stMask[nSteps]    = m;
                    nSteps++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic applyStep(input int i);
        hostAddr   = stAddr[i];
        hostWrData = stWrData[i];
        hostWr     = stHostCtl[i][0];
        hostRd     = stHostCtl[i][1];
        hostBe     = stHostCtl[i][3:2];
        bdalIn     = stBdal[i];
        {qReplyIn, qInitIn, qDmgIn, qBs7In, qWtbtIn, qDoutIn, qDinIn, qSyncIn} = stQin[i];
    endtask

    task automatic checkStep(input int i);
        string tag;
        tag = $sformatf("step %0d", i);
        if (stMask[i][0]) checkValue(32'(hostRdData), 32'(stExpRd[i]), {tag, " hostRdData"});
        if (stMask[i][1]) checkValue(32'(bdalOut), 32'(stExpOut[i]), {tag, " bdalOut"});
        if (stMask[i][2])
        begin
            checkValue(32'(sigVec), 32'(stExpSig[i]), {tag, " output lines"});
            checkValue(32'(bdalOe), 32'({22{stExpSig[i][5]}}), {tag, " bdalOe"});
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        traceLoaded      = 1'b0;
        F_IP_read_enable = 1'b1;
        hostAddr         = '0;
        hostWrData       = '0;
        hostBe           = 2'b00;
        hostWr           = 1'b0;
        hostRd           = 1'b0;
        bdalIn           = '1;                      // Idle bus is high
        {qReplyIn, qInitIn, qDmgIn, qBs7In, qWtbtIn, qDoutIn, qDinIn, qSyncIn} = 8'hFF;
        loadTrace();
        traceLoaded = 1'b1;
        repeat (10) @(posedge BRPLYf);
        @(negedge BRPLYf);
        F_IP_read_enable = 1'b0;
        @(negedge BRPLYf);
        for (int i = 0; i < nSteps; i++)
        begin
            applyStep(i);
            @(posedge BRPLYf);
            #40;                                    // Just before the next falling edge
            checkStep(i);
            @(negedge BRPLYf);
        end
        if (nSteps > 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("The trace held no steps to run");
            $display("RESULT: FAIL");
            $fatal(1, "Empty trace");
        end
    end

    // Watchdog allows one clock per step plus reset and margin
    initial
    begin
        wait (traceLoaded);
        repeat (nSteps + 20) #100;
        $display("Timeout: the trace did not finish in the expected time");
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: testbench/bridgeTrace.txt
# addr wdata hctl(be1 be0 rd wr) bdalIn qin(reply init dmg bs7 wtbt dout din sync)
# expRd expBdalOut expLines(irq6..sync oeAll busAck dmgOut replyOut outbound hostIrq) mask
000000 0000 0 3FFFFF FF 0000 000000 0000 7
# Host byte writes and reads
00000A 1234 D 3FFFFF FF 0000 000000 0000 7
00000A AB00 9 3FFFFF FF 0000 000000 0000 7
00000A 00CD 5 3FFFFF FF 0000 000000 0000 7
00000A 0000 2 3FFFFF FF ABCD 000000 0000 7
000008 FFFF D 3FFFFF FF 0000 000000 0000 7
000008 0000 2 3FFFFF FF 003F 000000 0000 7
000006 5678 D 3FFFFF FF 0000 000000 0000 7
000006 0000 2 3FFFFF FF 5678 000000 0000 7
00000C 0000 2 3F5A3C FF A5C3 000000 0000 7
000002 2468 D 3FFFFF FF 0000 000000 0000 7
# PDP-11 byte write to SA high byte, then a word write
000000 0000 0 000B94 EE 0000 000000 0000 7
000000 0000 0 3FA588 F2 0000 000000 0001 7
000000 0000 0 3FA588 F2 0000 000000 0005 7
000000 0000 0 3FFFFF FE 0000 000000 0005 7
000000 0000 0 3FFFFF FF 0000 000000 0001 7
000002 0000 2 3FFFFF FF 5A00 000000 0001 7
000000 0000 0 000B95 EE 0000 000000 0001 7
000000 0000 0 3FECA8 FA 0000 000000 0001 7
000000 0000 0 3FECA8 FA 0000 000000 0005 7
000000 0000 0 3FFFFF FE 0000 000000 0005 7
000000 0000 0 3FFFFF FF 0000 000000 0001 7
000002 0000 2 3FFFFF FF 1357 000000 0001 7
# IP read snapshot and clear, with clearSa set
000004 1000 D 3FFFFF FF 0000 000000 0001 7
000000 0000 2 3FFFFF FF 0008 000000 0001 7
000000 0000 0 3FFFFF FF 0000 000000 0000 7
000002 0000 2 3FFFFF FF 0000 000000 0000 7
# PDP-11 read of SA, slave drive window
000000 0000 0 000B95 EE 0000 000000 0000 7
000000 0000 0 3FFFFF FC 0000 002468 0023 7
000000 0000 0 3FFFFF FC 0000 002468 0027 7
000000 0000 0 3FFFFF 7C 0000 002468 0027 7
000000 0000 0 3FFFFF 7E 0000 002468 0027 7
000000 0000 0 3FFFFF FE 0000 000000 0001 7
000000 0000 0 3FFFFF FF 0000 000000 0001 7
000000 0000 2 3FFFFF FF 0034 000000 0001 7
000000 0000 0 3FFFFF FF 0000 000000 0000 7
# Grant pass-through, DMA grant, master drive and release
000000 0000 0 3FFFFF DF 0000 000000 0008 7
000000 0000 0 3FFFFF FF 0000 000000 0000 7
000004 0410 D 3FFFFF FF 0000 000000 0400 7
000000 0000 0 3FFFFF DF 0000 3F5678 0432 7
000000 0000 0 3FFFFF FF 0000 3F5678 0432 7
000004 0810 D 3FFFFF FF 0000 00ABCD 0432 7
000000 0000 0 000B95 EE 0000 00ABCD 0432 7
000000 0000 0 3FFFFF FC 0000 00ABCD 0433 7
000000 0000 0 3FFFFF FC 0000 00ABCD 0433 7
000000 0000 0 3FFFFF 7F 0000 00ABCD 0433 7
000000 0000 0 3FFFFF FF 0000 00ABCD 0433 7
000004 8810 D 3FFFFF FF 0000 000000 0401 7
000004 0000 D 3FFFFF FF 0000 000000 0001 7
# PDP-11 write to IP clears host registers, test register stays
000000 0000 2 3FFFFF FF 0034 000000 0001 7
000000 0000 0 3FFFFF FF 0000 000000 0000 7
00000E 0001 D 3FFFFF FF 0000 000000 0001 7
000004 0040 D 3FFFFF FF 0000 000000 1001 7
000000 0000 0 000B97 EE 0000 000000 1001 7
000000 0000 0 3FFFFF FA 0000 000000 0001 7
000000 0000 0 3FFFFF FA 0000 000000 0005 7
000000 0000 0 3FFFFF FE 0000 000000 0005 7
000000 0000 0 3FFFFF FF 0000 000000 0001 7
00000E 0000 2 3FFFFF FF 0001 000000 0001 7
00000A 0000 2 3FFFFF FF 0000 000000 0001 7
000006 0000 2 3FFFFF FF 0000 000000 0001 7
000008 0000 2 3FFFFF FF 0000 000000 0001 7
000004 0000 2 3FFFFF FF 0000 000000 0001 7
000000 0000 2 3FFFFF FF 0002 000000 0001 7
000000 0000 0 3FFFFF FF 0000 000000 0001 7
00000E 0000 D 3FFFFF FF 0000 000000 0000 7
000000 0000 0 3FFFFF FF 0000 000000 0000 7

// File: vlog.f
common/qbusPkg.sv
common/hostPkg.sv
host/hostRegs.sv
qbus/qbusSlave.sv
qbus/busMaster.sv
logic/bdalArbiter.sv
logic/qbusBridge.sv
testbench/tbBridge.sv

// File: run.sh
#!/bin/sh
# Build the Qbus bridge testbench with Verilator, run it from the project root
# and decide pass or fail from the printed result line
verilator --binary --timing -f vlog.f --top-module tbBridge -o tbBridge || exit 1
out=$(./obj_dir/tbBridge)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
